/* Makefile */
# Verilator build and run of the vertical scaler testbench

VERILATOR ?= verilator
TOP       ?= tb_scaler_v
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

# the simulator exits non-zero on a failed run
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_scaler_v.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_scaler_v;

    localparam int FRAME_LINES = 12;
    localparam int LINE_SIZE = 16;
    localparam int H_BLANK = 48;
    localparam int DONE_TIMEOUT = 1000;
    localparam int MODE_FLAT = 0;
    localparam int MODE_RANDOM = 1;
    localparam int MODE_EDGES = 2;

    logic        clk;
    logic        reset_i;
    logic [7:0]  di_i;
    logic        de_i;
    logic        hs_i;
    logic        vs_i;
    logic [15:0] scale_step_i;
    logic [15:0] scale_line_size_i;
    logic [7:0]  do_o;
    logic        de_o;
    logic        hs_o;
    logic        vs_o;

    // current frame image and expected output pixels
    logic [7:0]  img [FRAME_LINES][LINE_SIZE];
    logic [7:0]  exp_q [$];
    logic [31:0] lfsr = 32'h5138_f9c4;
    int          pix_expected = 0;
    int          pix_seen = 0;
    int          lines_seen = 0;
    int          line_pix = 0;
    logic        in_line = 1'b0;
    int          clamp_lo = 0;
    int          clamp_hi = 0;
    // vs_i over the last five sampled cycles
    logic [4:0]  vs_hist = '0;

    scaler_v #(
        .SPARSE_OUTPUT (0)
    ) i_scaler_v (
        .clk               (clk),
        .reset_i           (reset_i),
        .di_i              (di_i),
        .de_i              (de_i),
        .hs_i              (hs_i),
        .vs_i              (vs_i),
        .scale_step_i      (scale_step_i),
        .scale_line_size_i (scale_line_size_i),
        .do_o              (do_o),
        .de_o              (de_o),
        .hs_o              (hs_o),
        .vs_o              (vs_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input longint actual, input longint expected);
        if (actual != expected) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            fail_run("value check failed");
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per pixel bit
    task automatic draw_pixel(output logic [7:0] p);
        p = '0;
        for (int b = 0; b < 8; b++) begin
            lfsr = lfsr_step(lfsr);
            p = {p[6:0], lfsr[0]};
        end
    endtask

    // catmull-rom magnitudes times 512 for a phase in 1/1024 steps
    function automatic longint tap_weight(input longint phase, input int k);
        longint u;
        longint w0;
        longint w2;
        longint w3;
        u = 1024 - phase;
        w0 = (phase * u * u + (longint'(1) << 21)) / (longint'(1) << 22);
        w2 = (phase * (1048576 + 4096 * phase - 3 * phase * phase) + (longint'(1) << 21))
            / (longint'(1) << 22);
        w3 = (phase * phase * u + (longint'(1) << 21)) / (longint'(1) << 22);
        if (k == 0) begin
            return w0;
        end else if (k == 1) begin
            // center tap takes the rounding error so the net gain is exactly 512
            return 512 - w2 + w0 + w3;
        end else if (k == 2) begin
            return w2;
        end
        return w3;
    endfunction

    // rounded weighted sum with the outer taps negative
    function automatic longint filter_sum(input int p0, input int p1, input int p2,
                                          input int p3, input int phase);
        return p1 * tap_weight(phase, 1) + p2 * tap_weight(phase, 2)
            - p0 * tap_weight(phase, 0) - p3 * tap_weight(phase, 3) + 256;
    endfunction

    function automatic logic [7:0] round_clamp(input longint acc);
        if (acc < 0) begin
            return 8'h00;
        end else if ((acc >>> 9) > 255) begin
            return 8'hff;
        end
        return 8'((acc >>> 9));
    endfunction

    task automatic fill_frame(input int mode, input logic [7:0] flat);
        logic [7:0] p;
        for (int l = 0; l < FRAME_LINES; l++) begin
            for (int c = 0; c < LINE_SIZE; c++) begin
                if (mode == MODE_FLAT) begin
                    p = flat;
                end else begin
                    draw_pixel(p);
                end
                img[l][c] = p;
            end
            // hard vertical edges in columns 0 and 1 overshoot past both clamps
            if (mode == MODE_EDGES) begin
                img[l][0] = (l % 4 == 1 || l % 4 == 2) ? 8'hff : 8'h00;
                img[l][1] = ~img[l][0];
            end
        end
    endtask

    // walk output positions from 3.0 while four lines are available
    task automatic build_expected(input int step, input int mode, input logic [7:0] flat,
                                  output int n_lines);
        int     y;
        int     f;
        int     ph;
        longint acc;
        y = 3 << 12;
        n_lines = 0;
        while ((y >> 12) + 1 <= FRAME_LINES) begin
            f = y >> 12;
            ph = (y >> 2) & 1023;
            for (int c = 0; c < LINE_SIZE; c++) begin
                // newest line on tap0 and oldest on tap3
                acc = filter_sum(img[f][c], img[f-1][c], img[f-2][c], img[f-3][c], ph);
                if (acc < 0) begin
                    clamp_lo++;
                end else if ((acc >>> 9) > 255) begin
                    clamp_hi++;
                end
                if (mode == MODE_FLAT) begin
                    check_value("reference pixel", round_clamp(acc), flat);
                end
                exp_q.push_back(round_clamp(acc));
                pix_expected++;
            end
            n_lines++;
            y += step;
        end
    endtask

    task automatic drive_frame();
        // vs falling edge restarts the position
        repeat (4) begin
            @(posedge clk);
            vs_i <= 1'b1;
        end
        repeat (4) begin
            @(posedge clk);
            vs_i <= 1'b0;
        end
        for (int l = 0; l < FRAME_LINES; l++) begin
            for (int c = 0; c < LINE_SIZE; c++) begin
                @(posedge clk);
                de_i <= 1'b1;
                hs_i <= 1'b0;
                di_i <= img[l][c];
            end
            // long blanking holds both output lines of an upscale
            for (int b = 0; b < H_BLANK; b++) begin
                @(posedge clk);
                de_i <= 1'b0;
                di_i <= 8'h00;
                hs_i <= (b >= 8 && b < 12);
            end
        end
    endtask

    task automatic wait_frame_done();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 || in_line) begin
            @(posedge clk);
            cycles++;
            if (cycles > DONE_TIMEOUT) begin
                fail_run("timeout waiting for the output lines of a frame");
            end
        end
    endtask

    task automatic run_frame(input int mode, input logic [7:0] flat, input int step);
        int lines_before;
        int lines_expected;
        fill_frame(mode, flat);
        build_expected(step, mode, flat, lines_expected);
        lines_before = lines_seen;
        @(posedge clk);
        scale_step_i <= 16'(step);
        drive_frame();
        wait_frame_done();
        check_value("output lines", lines_seen - lines_before, lines_expected);
    endtask

    // output monitor samples away from the driving edge
    always @(negedge clk) begin
        if (!reset_i) begin
            // vs_o trails vs_i by the input register and four output stages
            check_value("vs_o", vs_o, vs_hist[4]);
            vs_hist = {vs_hist[3:0], vs_i};
            if (!hs_o) begin
                if (!in_line) begin
                    in_line = 1'b1;
                    line_pix = 0;
                end
            end else if (in_line) begin
                in_line = 1'b0;
                lines_seen++;
                check_value("de_o pulses per line", line_pix, LINE_SIZE);
            end
            if (de_o) begin
                check_value("hs_o", hs_o, 0);
                if (exp_q.size() == 0) begin
                    fail_run("de_o pulsed with no pixel expected");
                end else begin
                    check_value("do_o", do_o, exp_q.pop_front());
                end
                pix_seen++;
                line_pix++;
            end
        end
    end

    initial begin
        reset_i = 1'b1;
        di_i = 8'h00;
        de_i = 1'b0;
        hs_i = 1'b0;
        vs_i = 1'b0;
        scale_step_i = 16'd4096;
        scale_line_size_i = 16'(LINE_SIZE);
        repeat (5) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        check_value("de_o", de_o, 0);
        check_value("hs_o", hs_o, 1);
        // flat and random at 1:1 then down, up and up again on a fresh frame
        run_frame(MODE_FLAT, 8'h5a, 4096);
        run_frame(MODE_RANDOM, 8'h00, 4096);
        run_frame(MODE_EDGES, 8'h00, 6144);
        run_frame(MODE_EDGES, 8'h00, 2560);
        run_frame(MODE_EDGES, 8'h00, 2560);
        if (exp_q.size() == 0 && pix_seen == pix_expected && clamp_lo > 0 && clamp_hi > 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("pixels left %0d, seen %0d of %0d, clamps low %0d high %0d",
                     exp_q.size(), pix_seen, pix_expected, clamp_lo, clamp_hi);
            $display("Test failed");
            $fatal(1, "end of run checks");
        end
    end

endmodule

`default_nettype wire

/* design/scaler_coe_rom.sv */
`timescale 1ns/10ps
`default_nettype none

module scaler_coe_rom #(
    parameter int COE_W = scaler_pkg::COE_W,
    parameter int PHASE_W = scaler_pkg::PHASE_W
) (
    input  logic                clk,
    input  logic                reset_i,
    input  scaler_pkg::phase_t  phase_i,
    output scaler_pkg::coe_t    coe0_o,
    output scaler_pkg::coe_t    coe1_o,
    output scaler_pkg::coe_t    coe2_o,
    output scaler_pkg::coe_t    coe3_o
);
    import scaler_pkg::*;

    // one table per tap, indexed by phase
    logic [COE_W-1:0] rom [4][2**PHASE_W];

    // contents fixed at elaboration
    initial begin
        for (int p = 0; p < 2**PHASE_W; p++) begin
            for (int k = 0; k < 4; k++) begin
                rom[k][p] = cubic_weight(phase_t'(p), k);
            end
        end
    end

    // registered read, phase is held for the whole line
    always_ff @(posedge clk) begin
        if (reset_i) begin
            coe0_o <= '0;
            coe1_o <= '0;
            coe2_o <= '0;
            coe3_o <= '0;
        end else begin
            coe0_o <= rom[0][phase_i];
            coe1_o <= rom[1][phase_i];
            coe2_o <= rom[2][phase_i];
            coe3_o <= rom[3][phase_i];
        end
    end

endmodule

`default_nettype wire

/* design/scaler_filter.sv */
`timescale 1ns/10ps
`default_nettype none

module scaler_filter #(
    parameter int PIX_W = video_pkg::PIX_W,
    parameter int COE_W = scaler_pkg::COE_W
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic [PIX_W-1:0]  tap0_i,
    input  logic [PIX_W-1:0]  tap1_i,
    input  logic [PIX_W-1:0]  tap2_i,
    input  logic [PIX_W-1:0]  tap3_i,
    input  logic [COE_W-1:0]  coe0_i,
    input  logic [COE_W-1:0]  coe1_i,
    input  logic [COE_W-1:0]  coe2_i,
    input  logic [COE_W-1:0]  coe3_i,
    input  logic              rd_en_i,
    input  logic              line_active_i,
    input  logic              vs_d_i,
    output logic [PIX_W-1:0]  do_o,
    output logic              de_o,
    output logic              hs_o,
    output logic              vs_o
);
    localparam int MUL_W = PIX_W + COE_W;
    // two guard bits for the signed sum
    localparam int SUM_W = MUL_W + 2;
    localparam int ROUND = 1 << (COE_W - 2);
    // store read plus three filter stages
    localparam int LAT = 4;

    logic [MUL_W-1:0]        prod0;
    logic [MUL_W-1:0]        prod1;
    logic [MUL_W-1:0]        prod2;
    logic [MUL_W-1:0]        prod3;
    logic signed [SUM_W-1:0] acc;
    logic [LAT-1:0]          de_sr;
    logic [LAT-1:0]          hs_sr;
    logic [LAT-1:0]          vs_sr;

    always_ff @(posedge clk) begin
        // stage 1 products
        prod0 <= MUL_W'(tap0_i) * MUL_W'(coe0_i);
        prod1 <= MUL_W'(tap1_i) * MUL_W'(coe1_i);
        prod2 <= MUL_W'(tap2_i) * MUL_W'(coe2_i);
        prod3 <= MUL_W'(tap3_i) * MUL_W'(coe3_i);
        // stage 2, outer taps are negative lobes
        acc <= $signed({2'b00, prod1}) + $signed({2'b00, prod2})
            - $signed({2'b00, prod0}) - $signed({2'b00, prod3})
            + $signed(SUM_W'(ROUND));
        // stage 3 drop unity scale and clamp
        if (acc[SUM_W-1]) begin
            do_o <= '0;
        end else if (acc[SUM_W-2:COE_W-1+PIX_W] != '0) begin
            do_o <= '1;
        end else begin
            do_o <= acc[COE_W-1 +: PIX_W];
        end
    end

    // strobes ride alongside the data, several pixels may be in flight
    always_ff @(posedge clk) begin
        if (reset_i) begin
            de_sr <= '0;
            hs_sr <= '1;
            vs_sr <= '0;
        end else begin
            de_sr <= {de_sr[LAT-2:0], rd_en_i};
            hs_sr <= {hs_sr[LAT-2:0], ~line_active_i};
            vs_sr <= {vs_sr[LAT-2:0], vs_d_i};
        end
    end

    assign de_o = de_sr[LAT-1];
    assign hs_o = hs_sr[LAT-1];
    assign vs_o = vs_sr[LAT-1];

endmodule

`default_nettype wire

/* design/scaler_line_store.sv */
`timescale 1ns/10ps
`default_nettype none

module scaler_line_store #(
    parameter int LINE_SIZE_MAX = video_pkg::LINE_MAX,
    parameter int PIX_W = video_pkg::PIX_W
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              wr_en_i,
    input  video_pkg::pix_t   wr_data_i,
    input  video_pkg::col_t   wr_col_i,
    input  logic              line_done_i,
    input  logic              frame_start_i,
    input  logic              rd_en_i,
    input  video_pkg::col_t   rd_col_i,
    output logic [PIX_W-1:0]  tap0_o,
    output logic [PIX_W-1:0]  tap1_o,
    output logic [PIX_W-1:0]  tap2_o,
    output logic [PIX_W-1:0]  tap3_o
);
    localparam int ADDR_W = $clog2(LINE_SIZE_MAX);

    // five line buffers, one is always being filled
    logic [PIX_W-1:0] line_mem [5][LINE_SIZE_MAX];
    logic [2:0]       wr_ptr;
    // buffer index per tap, newest complete line first
    logic [2:0]       rd_sel [4];

    // ring pointer
    always_ff @(posedge clk) begin
        if (reset_i || frame_start_i) begin
            wr_ptr <= 3'd0;
        end else if (line_done_i) begin
            wr_ptr <= (wr_ptr == 3'd4) ? 3'd0 : wr_ptr + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            line_mem[wr_ptr][wr_col_i[ADDR_W-1:0]] <= wr_data_i;
        end
    end

    // tap k sits at (wr_ptr - 1 - k) mod 5
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            if (wr_ptr > 3'(k)) begin
                rd_sel[k] = wr_ptr - 3'(k) - 3'd1;
            end else begin
                rd_sel[k] = wr_ptr + 3'd4 - 3'(k);
            end
        end
    end

    // same column from the four complete lines
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            tap0_o <= line_mem[rd_sel[0]][rd_col_i[ADDR_W-1:0]];
            tap1_o <= line_mem[rd_sel[1]][rd_col_i[ADDR_W-1:0]];
            tap2_o <= line_mem[rd_sel[2]][rd_col_i[ADDR_W-1:0]];
            tap3_o <= line_mem[rd_sel[3]][rd_col_i[ADDR_W-1:0]];
        end
    end

    // input lines longer than the buffer would wrap onto older pixels
    a_wr_col_range: assert property (@(posedge clk) disable iff (reset_i)
        wr_en_i |-> (wr_col_i < LINE_SIZE_MAX));

endmodule

`default_nettype wire

/* design/scaler_pkg.sv */
`default_nettype none

package scaler_pkg;

    // 4.12 step and 12.12 line position
    localparam int STEP_FRAC = 12;
    typedef logic [23:0] pos_t;
    typedef logic [15:0] step_t;

    // coefficient magnitudes, unity is 512
    localparam int COE_W = 10;
    typedef logic [COE_W-1:0] coe_t;

    // phase is the top bits of the position fraction
    localparam int PHASE_W = 10;
    typedef logic [PHASE_W-1:0] phase_t;

    localparam longint PH_ONE = longint'(1) << PHASE_W;
    localparam longint UNITY = longint'(1) << (COE_W - 1);
    // t^3 terms carry 3*PHASE_W fraction bits, weights are halved
    localparam int W_SHIFT = 3 * PHASE_W - (COE_W - 2);
    localparam longint W_HALF = longint'(1) << (W_SHIFT - 1);

    // catmull-rom tap magnitude for tap k at phase t
    // taps 0 and 3 are subtracted, taps 1 and 2 added
    function automatic coe_t cubic_weight(input phase_t phase, input int k);
        longint t;
        longint u;
        longint w0;
        longint w1;
        longint w2;
        longint w3;
        t = longint'(phase);
        u = PH_ONE - t;
        w0 = (t * u * u + W_HALF) >>> W_SHIFT;
        w2 = (t * (PH_ONE * PH_ONE + 4 * PH_ONE * t - 3 * t * t) + W_HALF) >>> W_SHIFT;
        w3 = (t * t * u + W_HALF) >>> W_SHIFT;
        // tap1 absorbs rounding so the signed sum is exactly unity
        w1 = UNITY - w2 + w0 + w3;
        case (k)
            0: return coe_t'(w0);
            1: return coe_t'(w1);
            2: return coe_t'(w2);
            default: return coe_t'(w3);
        endcase
    endfunction

endpackage

`default_nettype wire

/* design/scaler_v.sv */
`timescale 1ns/10ps
`default_nettype none

module scaler_v #(
    // idle cycles between output pixels
    parameter int SPARSE_OUTPUT = 2,
    parameter int LINE_SIZE_MAX = video_pkg::LINE_MAX,
    parameter int PIX_W = video_pkg::PIX_W
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic [PIX_W-1:0]   di_i,
    input  logic               de_i,
    input  logic               hs_i,
    input  logic               vs_i,
    // 4.12, 4096 is 1.0
    input  scaler_pkg::step_t  scale_step_i,
    input  video_pkg::col_t    scale_line_size_i,
    output logic [PIX_W-1:0]   do_o,
    output logic               de_o,
    output logic               hs_o,
    output logic               vs_o
);
    import video_pkg::*;
    import scaler_pkg::*;

    logic             wr_en;
    pix_t             wr_data;
    col_t             wr_col;
    logic             line_done;
    logic             frame_start;
    logic             rd_en;
    col_t             rd_col;
    phase_t           phase;
    coe_t             coe0;
    coe_t             coe1;
    coe_t             coe2;
    coe_t             coe3;
    logic [PIX_W-1:0] tap0;
    logic [PIX_W-1:0] tap1;
    logic [PIX_W-1:0] tap2;
    logic [PIX_W-1:0] tap3;
    logic             line_active;
    logic             vs_d;

    scaler_v_ctrl #(
        .SPARSE_OUTPUT (SPARSE_OUTPUT),
        .LINE_SIZE_MAX (LINE_SIZE_MAX)
    ) i_ctrl (
        .clk               (clk),
        .reset_i           (reset_i),
        .de_i              (de_i),
        .hs_i              (hs_i),
        .vs_i              (vs_i),
        .di_i              (di_i),
        .scale_step_i      (scale_step_i),
        .scale_line_size_i (scale_line_size_i),
        .wr_en_o           (wr_en),
        .wr_data_o         (wr_data),
        .wr_col_o          (wr_col),
        .line_done_o       (line_done),
        .frame_start_o     (frame_start),
        .rd_en_o           (rd_en),
        .rd_col_o          (rd_col),
        .phase_o           (phase),
        .line_active_o     (line_active),
        .vs_d_o            (vs_d)
    );

    scaler_line_store #(
        .LINE_SIZE_MAX (LINE_SIZE_MAX),
        .PIX_W         (PIX_W)
    ) i_store (
        .clk           (clk),
        .reset_i       (reset_i),
        .wr_en_i       (wr_en),
        .wr_data_i     (wr_data),
        .wr_col_i      (wr_col),
        .line_done_i   (line_done),
        .frame_start_i (frame_start),
        .rd_en_i       (rd_en),
        .rd_col_i      (rd_col),
        .tap0_o        (tap0),
        .tap1_o        (tap1),
        .tap2_o        (tap2),
        .tap3_o        (tap3)
    );

    scaler_coe_rom #(
        .COE_W   (COE_W),
        .PHASE_W (PHASE_W)
    ) i_rom (
        .clk     (clk),
        .reset_i (reset_i),
        .phase_i (phase),
        .coe0_o  (coe0),
        .coe1_o  (coe1),
        .coe2_o  (coe2),
        .coe3_o  (coe3)
    );

    scaler_filter #(
        .PIX_W (PIX_W),
        .COE_W (COE_W)
    ) i_filter (
        .clk           (clk),
        .reset_i       (reset_i),
        .tap0_i        (tap0),
        .tap1_i        (tap1),
        .tap2_i        (tap2),
        .tap3_i        (tap3),
        .coe0_i        (coe0),
        .coe1_i        (coe1),
        .coe2_i        (coe2),
        .coe3_i        (coe3),
        .rd_en_i       (rd_en),
        .line_active_i (line_active),
        .vs_d_i        (vs_d),
        .do_o          (do_o),
        .de_o          (de_o),
        .hs_o          (hs_o),
        .vs_o          (vs_o)
    );

endmodule

`default_nettype wire

/* design/scaler_v_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module scaler_v_ctrl #(
    parameter int SPARSE_OUTPUT = 2,
    parameter int LINE_SIZE_MAX = video_pkg::LINE_MAX
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                de_i,
    input  logic                hs_i,
    input  logic                vs_i,
    input  video_pkg::pix_t     di_i,
    input  scaler_pkg::step_t   scale_step_i,
    input  video_pkg::col_t     scale_line_size_i,
    output logic                wr_en_o,
    output video_pkg::pix_t     wr_data_o,
    output video_pkg::col_t     wr_col_o,
    output logic                line_done_o,
    output logic                frame_start_o,
    output logic                rd_en_o,
    output video_pkg::col_t     rd_col_o,
    output scaler_pkg::phase_t  phase_o,
    output logic                line_active_o,
    output logic                vs_d_o
);
    import video_pkg::*;
    import scaler_pkg::*;

    localparam int LCNT_W = $bits(pos_t) - STEP_FRAC;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PARAM,
        ST_READ
    } state_t;

    // input register stage and one more for edges
    pix_t              di_q;
    logic              de_q;
    logic              hs_q;
    logic              vs_q;
    logic              de_qq;
    logic              hs_qq;
    logic              vs_qq;
    col_t              wr_col;
    logic [LCNT_W-1:0] in_lines;
    pos_t              out_pos;
    state_t            state;
    logic [7:0]        sparse_cnt;
    col_t              rd_cnt;

    always_ff @(posedge clk) begin
        di_q <= di_i;
        if (reset_i) begin
            de_q <= 1'b0;
            hs_q <= 1'b0;
            vs_q <= 1'b0;
            de_qq <= 1'b0;
            hs_qq <= 1'b0;
            vs_qq <= 1'b0;
        end else begin
            de_q <= de_i;
            hs_q <= hs_i;
            vs_q <= vs_i;
            de_qq <= de_q;
            hs_qq <= hs_q;
            vs_qq <= vs_q;
        end
    end

    // de falling ends a line and vs falling starts a frame
    assign line_done_o = de_qq & ~de_q;
    assign frame_start_o = vs_qq & ~vs_q;
    assign wr_en_o = de_q;
    assign wr_data_o = di_q;
    assign wr_col_o = wr_col;
    assign vs_d_o = vs_q;

    // write column realigned on any hs edge
    always_ff @(posedge clk) begin
        if (reset_i || frame_start_o || line_done_o || (hs_q ^ hs_qq)) begin
            wr_col <= '0;
        end else if (de_q) begin
            wr_col <= wr_col + 16'd1;
        end
    end

    // complete input lines in this frame
    always_ff @(posedge clk) begin
        if (reset_i || frame_start_o) begin
            in_lines <= '0;
        end else if (line_done_o) begin
            in_lines <= in_lines + 1'b1;
        end
    end

    // output line sequencer starting from position 3.0
    always_ff @(posedge clk) begin
        if (reset_i || frame_start_o) begin
            state <= ST_IDLE;
            out_pos <= pos_t'(3) << STEP_FRAC;
            sparse_cnt <= '0;
            rd_cnt <= '0;
            rd_en_o <= 1'b0;
            line_active_o <= 1'b0;
        end else begin
            rd_en_o <= 1'b0;
            line_active_o <= (state == ST_READ);
            case (state)
                ST_IDLE: begin
                    // enough lines stored for the next position
                    if ({in_lines, STEP_FRAC'(0)} > out_pos) begin
                        state <= ST_PARAM;
                    end
                end
                ST_PARAM: begin
                    // wait for coefficients of the latched phase
                    rd_cnt <= '0;
                    sparse_cnt <= '0;
                    state <= ST_READ;
                end
                ST_READ: begin
                    sparse_cnt <= (sparse_cnt == 8'(SPARSE_OUTPUT)) ? '0 : sparse_cnt + 8'd1;
                    if (sparse_cnt == '0) begin
                        rd_en_o <= 1'b1;
                        rd_cnt <= rd_cnt + 16'd1;
                        if (rd_cnt == scale_line_size_i - 16'd1) begin
                            out_pos <= out_pos + pos_t'(scale_step_i);
                            state <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // phase follows position until the line starts
    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            phase_o <= out_pos[STEP_FRAC-1 -: PHASE_W];
        end
        if (state == ST_READ && sparse_cnt == '0) begin
            rd_col_o <= rd_cnt;
        end
    end

    // no input line may complete under an output line
    // the ring would rotate and the taps would shift mid line
    a_no_rotate_in_read: assert property (@(posedge clk) disable iff (reset_i)
        line_active_o |-> !line_done_o);

    a_line_size: assert property (@(posedge clk) disable iff (reset_i)
        (state == ST_PARAM) |->
            (scale_line_size_i != '0 && scale_line_size_i <= LINE_SIZE_MAX));

endmodule

`default_nettype wire

/* design/video_pkg.sv */
`default_nettype none

// pixel and line geometry shared by the scaler blocks
package video_pkg;

    // one luma sample
    localparam int PIX_W = 8;

    typedef logic [PIX_W-1:0] pix_t;

    // default upper bound on active pixels per line
    // top level passes this on as LINE_SIZE_MAX
    localparam int LINE_MAX = 64;

    // column index and line length, same width as the line size input
    typedef logic [15:0] col_t;

endpackage

`default_nettype wire

/* flist.f */
design/video_pkg.sv
design/scaler_pkg.sv
design/scaler_coe_rom.sv
design/scaler_line_store.sv
design/scaler_v_ctrl.sv
design/scaler_filter.sv
design/scaler_v.sv
bench/tb_scaler_v.sv
